/* common/uartPkg.sv */
package uartPkg;

	////////////////////////////////////////////////////////////
	// serial framing, 8N1 with 16x oversampling
	////////////////////////////////////////////////////////////
	localparam int dataBits    = 8;    // data bits per frame
	localparam int sbTick      = 16;   // ticks in one stop bit
	localparam int overSample  = 16;   // ticks per bit
	localparam int fifoDepth   = 16;   // entries per fifo
	localparam int fifoAddrLen = 4;
	localparam int tickLen     = $clog2(overSample);
	localparam int bitCntLen   = $clog2(dataBits);

	// counter end points, shared by rx and tx
	localparam logic [tickLen-1:0]   midTick      = tickLen'(overSample / 2 - 1);
	localparam logic [tickLen-1:0]   lastTick     = tickLen'(overSample - 1);
	localparam logic [tickLen-1:0]   stopLastTick = tickLen'(sbTick - 1);
	localparam logic [bitCntLen-1:0] lastBit      = bitCntLen'(dataBits - 1);

	// frame phases, same for both directions
	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} frameState_t;

	// rx fifo entry, framing bit above the byte
	typedef struct packed {
		logic                frameErr;
		logic [dataBits-1:0] data;
	} rxWord_t;

	typedef logic [dataBits-1:0] txWord_t;   // tx fifo entry

endpackage

/* common/uartRegPkg.sv */
package uartRegPkg;

	////////////////////////////////////////////////////////////
	// apb register map
	////////////////////////////////////////////////////////////
	localparam int apbAddrLen = 4;

	localparam logic [apbAddrLen-1:0] regData    = 4'h0;   // rx pop / tx push
	localparam logic [apbAddrLen-1:0] regStatus  = 4'h4;
	localparam logic [apbAddrLen-1:0] regDivisor = 4'h8;   // clk cycles per sTick

	// status word bits
	localparam int statRxEmpty  = 0;
	localparam int statRxFull   = 1;
	localparam int statTxEmpty  = 2;
	localparam int statTxFull   = 3;
	localparam int statOverrun  = 4;   // sticky, write 1 to clear
	localparam int statFrameErr = 5;   // framing bit of rx head

	localparam int                    divisorLen   = 16;
	localparam logic [divisorLen-1:0] divisorReset = 16'd27;
	localparam logic [divisorLen-1:0] divisorMin   = 16'd1;   // a written 0 lands here

endpackage

/* uart/uartFifo.sv */
module uartFifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  logic     pop,
	input  payload_t wrData,
	output payload_t rdData,
	output logic     empty,
	output logic     full
);

	payload_t                          mem [uartPkg::fifoDepth];
	logic [uartPkg::fifoAddrLen-1:0]   wrPtr, rdPtr;   // wrap naturally at depth 16
	logic [uartPkg::fifoAddrLen:0]     count;          // one bit wider, holds 16
	logic                              doPush, doPop;

	assign doPush = push && !full;    // push on full dropped
	assign doPop  = pop && !empty;    // pop on empty dropped

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= wrData;
	end

	assign rdData = mem[rdPtr];   // head, no read latency
	assign empty  = (count == '0);
	assign full   = (count == (uartPkg::fifoAddrLen + 1)'(uartPkg::fifoDepth));

endmodule

/* uart/uartRec.sv */
module uartRec (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          sTick,
	input  logic                          rx,
	output logic                          rxDoneTick,
	output logic                          frameErr,
	output logic [uartPkg::dataBits-1:0]  dOut
);

	uartPkg::frameState_t             stateReg, stateNext;
	logic [uartPkg::tickLen-1:0]      sReg, sNext;   // oversample tick count
	logic [uartPkg::bitCntLen-1:0]    nReg, nNext;   // data bit index
	logic [uartPkg::dataBits-1:0]     bReg, bNext;   // shift reg, lsb arrives first

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::stIdle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
		end
	end

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		rxDoneTick = 1'b0;
		frameErr   = 1'b0;
		case (stateReg)
			uartPkg::stIdle:
				if (!rx)   // falling edge, start bit begins
				begin
					stateNext = uartPkg::stStart;
					sNext     = '0;
				end
			uartPkg::stStart:
				if (sTick)
				begin
					if (sReg == uartPkg::midTick)   // middle of start bit
					begin
						stateNext = uartPkg::stData;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stData:
				if (sTick)
				begin
					if (sReg == uartPkg::lastTick)   // middle of next data bit
					begin
						sNext = '0;
						bNext = {rx, bReg[uartPkg::dataBits-1:1]};
						if (nReg == uartPkg::lastBit)
							stateNext = uartPkg::stStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stStop:
				if (sTick)
				begin
					if (sReg == uartPkg::stopLastTick)   // middle of stop bit
					begin
						stateNext  = uartPkg::stIdle;
						rxDoneTick = 1'b1;
						frameErr   = !rx;   // stop bit must be high
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::stIdle;
		endcase
	end

	assign dOut = bReg;

endmodule

/* uart/uartTrans.sv */
module uartTrans (
	input  logic             clk,
	input  logic             reset,
	input  logic             sTick,
	input  logic             txStart,   // same cycle as the tx fifo pop
	input  uartPkg::txWord_t txData,
	output logic             tx,
	output logic             txReady
);

	uartPkg::frameState_t             stateReg, stateNext;
	logic [uartPkg::tickLen-1:0]      sReg, sNext;
	logic [uartPkg::bitCntLen-1:0]    nReg, nNext;
	logic [uartPkg::dataBits-1:0]     bReg, bNext;   // byte being shifted out
	logic                             txReg, txNext;  // registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::stIdle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
			txReg    <= 1'b1;   // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
			txReg    <= txNext;
		end
	end

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		txNext    = txReg;
		case (stateReg)
			uartPkg::stIdle:
			begin
				txNext = 1'b1;
				if (txStart)   // latch head word now
				begin
					stateNext = uartPkg::stStart;
					sNext     = '0;
					bNext     = txData;
					txNext    = 1'b0;   // start bit goes out next cycle
				end
			end
			uartPkg::stStart:
				if (sTick)
				begin
					if (sReg == uartPkg::lastTick)
					begin
						stateNext = uartPkg::stData;
						sNext     = '0;
						nNext     = '0;
						txNext    = bReg[0];   // first data bit, lsb
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stData:
				if (sTick)
				begin
					if (sReg == uartPkg::lastTick)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == uartPkg::lastBit)
						begin
							stateNext = uartPkg::stStop;
							txNext    = 1'b1;   // stop bit
						end
						else
						begin
							nNext  = nReg + 1'b1;
							txNext = bReg[1];   // next bit after the shift
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stStop:
				if (sTick)
				begin
					if (sReg == uartPkg::stopLastTick)
						stateNext = uartPkg::stIdle;
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::stIdle;
		endcase
	end

	assign tx      = txReg;
	assign txReady = (stateReg == uartPkg::stIdle);

endmodule

/* src/baudGen.sv */
module baudGen (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [uartRegPkg::divisorLen-1:0] divisor,
	output logic                              sTick
);

	logic [uartRegPkg::divisorLen-1:0] cntReg;   // counts down to zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cntReg <= uartRegPkg::divisorReset - 1'b1;
		else if (cntReg == '0)
			cntReg <= divisor - 1'b1;   // new divisor picked up here only
		else
			cntReg <= cntReg - 1'b1;
	end

	// one clk wide, every divisor cycles
	assign sTick = (cntReg == '0);

endmodule

/* src/uartRegs.sv */
module uartRegs (
	input  logic                              clk,
	input  logic                              reset,
	// apb
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [uartRegPkg::apbAddrLen-1:0] paddr,
	input  logic [31:0]                       pwdata,
	output logic [31:0]                       prdata,
	output logic                              pready,
	output logic                              pslverr,
	// datapath
	input  uartPkg::rxWord_t                  rxWord,   // rx fifo head
	input  logic                              rxEmpty,
	input  logic                              rxFull,
	input  logic                              txEmpty,
	input  logic                              txFull,
	input  logic                              rxPush,
	output logic                              rxPop,
	output logic                              txPush,
	output logic [uartRegPkg::divisorLen-1:0] divisor,
	output uartPkg::txWord_t                  txWord,
	output logic                              rxIrq
);

	logic                              access;   // second apb cycle
	logic                              hitData, hitStatus, hitDivisor;
	logic [uartRegPkg::divisorLen-1:0] wrDiv;
	logic [31:0]                       status;
	logic                              overrun;

	assign access     = psel && penable;
	assign hitData    = (paddr == uartRegPkg::regData);
	assign hitStatus  = (paddr == uartRegPkg::regStatus);
	assign hitDivisor = (paddr == uartRegPkg::regDivisor);
	assign wrDiv      = pwdata[uartRegPkg::divisorLen-1:0];

	////////////////////////////////////////////////////////////
	// divisor and overrun flag
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divisor <= uartRegPkg::divisorReset;
			overrun <= 1'b0;
		end
		else
		begin
			if (access && pwrite && hitDivisor)
				divisor <= (wrDiv == '0) ? uartRegPkg::divisorMin : wrDiv;
			if (rxPush && rxFull)   // word lost in the fifo, set wins over clear
				overrun <= 1'b1;
			else if (access && pwrite && hitStatus && pwdata[uartRegPkg::statOverrun])
				overrun <= 1'b0;
		end
	end

	always_comb
	begin
		status                           = '0;
		status[uartRegPkg::statRxEmpty]  = rxEmpty;
		status[uartRegPkg::statRxFull]   = rxFull;
		status[uartRegPkg::statTxEmpty]  = txEmpty;
		status[uartRegPkg::statTxFull]   = txFull;
		status[uartRegPkg::statOverrun]  = overrun;
		status[uartRegPkg::statFrameErr] = rxWord.frameErr && !rxEmpty;
	end

	// read mux
	always_comb
	begin
		prdata = '0;
		if (hitData && !rxEmpty)
			prdata = 32'(rxWord);   // framing bit lands at bit 8
		else if (hitStatus)
			prdata = status;
		else if (hitDivisor)
			prdata = 32'(divisor);
	end

	assign rxPop   = access && !pwrite && hitData && !rxEmpty;
	assign txPush  = access && pwrite && hitData;   // fifo drops it when full
	assign txWord  = pwdata[uartPkg::dataBits-1:0];
	assign pready  = 1'b1;   // never waits
	assign pslverr = access && !(hitData || hitStatus || hitDivisor);
	assign rxIrq   = !rxEmpty;

endmodule

/* src/uartTop.sv */
module uartTop (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [uartRegPkg::apbAddrLen-1:0] paddr,
	input  logic [31:0]                       pwdata,
	output logic [31:0]                       prdata,
	output logic                              pready,
	output logic                              pslverr,
	input  logic                              rx,
	output logic                              tx,
	output logic                              rxIrq
);

	uartPkg::rxWord_t                  rxHead, rxIn;
	uartPkg::txWord_t                  txHead, txIn;
	logic                              rxEmpty, rxFull, txEmpty, txFull;
	logic                              rxPush, rxPop, txPush, txPop;
	logic [uartRegPkg::divisorLen-1:0] divisor;
	logic                              sTick, frameErr, txReady;
	logic [uartPkg::dataBits-1:0]      recData;

	////////////////////////////////////////////////////////////
	// control side
	////////////////////////////////////////////////////////////
	uartRegs regs0 (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.rxWord(rxHead), .rxEmpty, .rxFull, .txEmpty, .txFull, .rxPush,
		.rxPop, .txPush, .divisor, .txWord(txIn), .rxIrq
	);

	baudGen baud0 (.clk, .reset, .divisor, .sTick);

	// receive path
	uartRec rec0 (
		.clk, .reset, .sTick, .rx,
		.rxDoneTick(rxPush), .frameErr, .dOut(recData)
	);

	assign rxIn = {frameErr, recData};

	uartFifo #(.payload_t(uartPkg::rxWord_t)) rxFifo (
		.clk, .reset, .push(rxPush), .pop(rxPop),
		.wrData(rxIn), .rdData(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	// transmit path
	uartFifo #(.payload_t(uartPkg::txWord_t)) txFifo (
		.clk, .reset, .push(txPush), .pop(txPop),
		.wrData(txIn), .rdData(txHead), .empty(txEmpty), .full(txFull)
	);

	assign txPop = txReady && !txEmpty;   // pop doubles as txStart

	uartTrans trans0 (
		.clk, .reset, .sTick, .txStart(txPop), .txData(txHead),
		.tx, .txReady
	);

endmodule

/* tests/uartTop_properties.sv */
module uartTop_properties (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rxDoneTick,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr
);
	timeunit 1ns;
	timeprecision 100ps;

	// receiver only finishes a frame on an oversample tick
	doneOnTick: assert property (@(posedge clk) disable iff (reset) rxDoneTick |-> sTick)
		else $error("rxDoneTick seen without sTick");

	// no wait states on this bus
	readyHigh: assert property (@(posedge clk) disable iff (reset) pready)
		else $error("pready dropped low");

	errInAccess: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> (psel && penable))   // error only in access phase
		else $error("pslverr outside an apb access cycle");

endmodule

// receiver side, apb inputs tied quiet
bind uartRec uartTop_properties recProps (
	.clk, .reset, .sTick, .rxDoneTick,
	.psel(1'b0), .penable(1'b0), .pready(1'b1), .pslverr(1'b0)
);

// register side, rx tick inputs tied quiet
bind uartRegs uartTop_properties regsProps (
	.clk, .reset, .sTick(1'b1), .rxDoneTick(1'b0),
	.psel, .penable, .pready, .pslverr
);

/* tests/uartTop_tb.sv */
module uartTop_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod   = 8;
	localparam int resetCycles = 3;
	localparam int txFrames    = 6;
	localparam int rxFrames    = 6;
	localparam int overFrames  = uartPkg::fifoDepth + 1;   // one more than fits
	localparam int newDivisor  = 13;
	localparam int frameTicks  = 160;   // 10 bits of 16 ticks
	// framing test costs about 3 frame times, divisor test 1
	localparam int totalFrames = txFrames + rxFrames + 3 + overFrames + 1;
	localparam longint runTime = longint'(totalFrames) * frameTicks
		* int'(uartRegPkg::divisorReset) * clkPeriod;
	localparam longint watchLimit = runTime + runTime / 4 + 100000;   // plus margin

	logic                              clk, reset;
	logic                              psel, penable, pwrite;
	logic [uartRegPkg::apbAddrLen-1:0] paddr;
	logic [31:0]                       pwdata, prdata;
	logic                              pready, pslverr;
	logic                              rx, tx, rxIrq;

	uartPkg::rxWord_t rxExpQ[$];   // expected rx words, in order
	uartPkg::rxWord_t rxGotQ[$];   // words read back, waiting for compare
	uartPkg::txWord_t txExpQ[$];   // bytes written, not yet seen on tx
	int               curDiv;      // divisor the line models use
	string            testName;

	uartTop dut0 (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .rx, .tx, .rxIrq
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// reference and checks
	////////////////////////////////////////////////////////////
	function automatic uartPkg::rxWord_t expectFrame(input uartPkg::txWord_t data,
		input logic stopBit);
		uartPkg::rxWord_t w;
		w.data     = data;
		w.frameErr = !stopBit;   // low stop sample flags the word
		return w;
	endfunction

	function automatic logic [31:0] statusWord(input logic rxEmpty, input logic rxFull,
		input logic txEmpty, input logic txFull, input logic overrun, input logic frameErr);
		logic [31:0] s;
		s                                = '0;
		s[uartRegPkg::statRxEmpty]  = rxEmpty;
		s[uartRegPkg::statRxFull]   = rxFull;
		s[uartRegPkg::statTxEmpty]  = txEmpty;
		s[uartRegPkg::statTxFull]   = txFull;
		s[uartRegPkg::statOverrun]  = overrun;
		s[uartRegPkg::statFrameErr] = frameErr;
		return s;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkRxWord(input uartPkg::rxWord_t exp, input uartPkg::rxWord_t act);
		if (act !== exp)
			abortRun($sformatf("mismatch in %s: expected %h, got %h", testName, exp, act));
	endtask

	task automatic checkTxWord(input uartPkg::txWord_t exp, input uartPkg::txWord_t act);
		if (act !== exp)
			abortRun($sformatf("mismatch in %s: expected %h, got %h", testName, exp, act));
	endtask

	task automatic checkStatus(input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			abortRun($sformatf("mismatch in %s: expected status %h, got %h",
				testName, exp, act));
	endtask

	task automatic checkDivisor(input logic [uartRegPkg::divisorLen-1:0] exp,
		input logic [uartRegPkg::divisorLen-1:0] act);
		if (act !== exp)
			abortRun($sformatf("mismatch in %s: expected divisor %h, got %h",
				testName, exp, act));
	endtask

	////////////////////////////////////////////////////////////
	// apb driver
	////////////////////////////////////////////////////////////
	task automatic apbTransfer(input logic write, input logic [uartRegPkg::apbAddrLen-1:0] addr,
		input logic [31:0] wdata, input logic expectErr, output logic [31:0] rdata);
		logic err;
		@(posedge clk);   // setup phase
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;   // access phase
		@(negedge clk);
		while (pready !== 1'b1)
			@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);   // transfer completes here
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		if (err !== expectErr)
			abortRun(expectErr ? "no pslverr for an unmapped address"
				: "pslverr raised for a mapped register");
	endtask

	task automatic apbWrite(input logic [uartRegPkg::apbAddrLen-1:0] addr,
		input logic [31:0] data);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, data, 1'b0, unused);
	endtask

	task automatic apbRead(input logic [uartRegPkg::apbAddrLen-1:0] addr,
		output logic [31:0] data);
		apbTransfer(1'b0, addr, '0, 1'b0, data);
	endtask

	task automatic expectStatus(input logic [31:0] exp);
		logic [31:0] rd;
		apbRead(uartRegPkg::regStatus, rd);
		checkStatus(exp, rd);
	endtask

	task automatic setDivisor(input int d);
		apbWrite(uartRegPkg::regDivisor, 32'(d));
		curDiv = d;
	endtask

	////////////////////////////////////////////////////////////
	// serial line model
	////////////////////////////////////////////////////////////
	task automatic holdBit(input logic level);
		@(posedge clk);
		rx <= level;
		repeat (uartPkg::overSample * curDiv - 1)
			@(posedge clk);
	endtask

	task automatic sendFrame(input uartPkg::txWord_t data, input logic stopBit);
		int i;
		holdBit(1'b0);   // start
		for (i = 0; i < uartPkg::dataBits; i++)
			holdBit(data[i]);   // lsb first
		holdBit(stopBit);
		if (!stopBit)
			repeat (10)
				holdBit(1'b1);   // idle long enough for the follow-on frame
	endtask

	// tx decoder, samples mid bit and compares against the written bytes
	initial
	begin
		uartPkg::txWord_t got;
		int               i;
		@(negedge reset);
		forever
		begin
			@(negedge tx);
			repeat (uartPkg::overSample / 2 * curDiv)
				@(posedge clk);
			@(negedge clk);
			if (tx !== 1'b0)
				abortRun("start bit on tx did not last to its middle");
			for (i = 0; i < uartPkg::dataBits; i++)
			begin
				repeat (uartPkg::overSample * curDiv)
					@(posedge clk);
				@(negedge clk);
				got[i] = tx;
			end
			repeat (uartPkg::overSample * curDiv)
				@(posedge clk);
			@(negedge clk);
			if (tx !== 1'b1)
				abortRun("stop bit on tx was not high");
			else if (txExpQ.size() == 0)
				abortRun("a frame appeared on tx with no byte written");
			else
				checkTxWord(txExpQ.pop_front(), got);
		end
	end

	// compare process for the rx path
	initial
	begin
		forever
		begin
			@(negedge clk);
			while (rxGotQ.size() != 0)
			begin
				if (rxExpQ.size() == 0)
					abortRun("read back a received word that was never sent");
				else
					checkRxWord(rxExpQ.pop_front(), rxGotQ.pop_front());
			end
		end
	end

	task automatic waitRxData();
		int c;
		c = 0;
		while (rxIrq !== 1'b1 && c < 2 * frameTicks * curDiv)
		begin
			@(negedge clk);
			c++;
		end
		if (rxIrq !== 1'b1)
			abortRun("rxIrq stayed low, no received word showed up");
	endtask

	task automatic readWords(input int n);
		logic [31:0] rd;
		int          k;
		for (k = 0; k < n; k++)
		begin
			waitRxData();
			apbRead(uartRegPkg::regData, rd);
			rxGotQ.push_back(uartPkg::rxWord_t'(rd[8:0]));
		end
		while (rxGotQ.size() != 0)
			@(negedge clk);
		if (rxExpQ.size() != 0)
			abortRun("some expected received words were never read back");
		else if (rxIrq !== 1'b0)
			abortRun("rxIrq still high with the receive FIFO drained");
	endtask

	// watchdog
	initial
	begin
		#(watchLimit);
		abortRun("timeout, the tests did not finish in time");
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		logic [31:0]      rd;
		uartPkg::txWord_t b;
		int               k;
		void'($urandom(32'h60c5));
		clk        = 1'b0;
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		rx         = 1'b1;   // line idle
		curDiv     = int'(uartRegPkg::divisorReset);
		repeat (resetCycles)
			@(posedge clk);
		reset <= 1'b0;

		testName = "reset";
		@(negedge clk);
		if (tx !== 1'b1 || rxIrq !== 1'b0)
			abortRun("tx not idle high or rxIrq set after reset");
		expectStatus(statusWord(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		apbRead(uartRegPkg::regDivisor, rd);
		checkDivisor(uartRegPkg::divisorReset, rd[uartRegPkg::divisorLen-1:0]);
		apbRead(uartRegPkg::regData, rd);   // empty fifo reads 0
		checkRxWord(uartPkg::rxWord_t'(9'h0), uartPkg::rxWord_t'(rd[8:0]));

		testName = "divisor readback";
		apbWrite(uartRegPkg::regDivisor, 32'h00b5);
		apbRead(uartRegPkg::regDivisor, rd);
		checkDivisor(16'h00b5, rd[uartRegPkg::divisorLen-1:0]);
		apbWrite(uartRegPkg::regDivisor, 32'h0);
		apbRead(uartRegPkg::regDivisor, rd);
		checkDivisor(16'h0001, rd[uartRegPkg::divisorLen-1:0]);   // 0 is held as 1
		setDivisor(int'(uartRegPkg::divisorReset));

		testName = "unmapped address";
		apbTransfer(1'b0, 4'hc, '0, 1'b1, rd);

		testName = "transmit";
		for (k = 0; k < txFrames; k++)
		begin
			b = uartPkg::txWord_t'($urandom());
			txExpQ.push_back(b);
			apbWrite(uartRegPkg::regData, 32'(b));
		end
		while (txExpQ.size() != 0)
			@(negedge clk);
		expectStatus(statusWord(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

		testName = "receive";
		for (k = 0; k < rxFrames; k++)
		begin
			b = uartPkg::txWord_t'($urandom());
			rxExpQ.push_back(expectFrame(b, 1'b1));
			sendFrame(b, 1'b1);
		end
		readWords(rxFrames);

		testName = "framing error";
		b = uartPkg::txWord_t'($urandom());
		rxExpQ.push_back(expectFrame(b, 1'b0));
		// line still low after the bad stop looks like a new start bit, then all ones
		rxExpQ.push_back(expectFrame(8'hff, 1'b1));
		sendFrame(b, 1'b0);
		b = uartPkg::txWord_t'($urandom());
		rxExpQ.push_back(expectFrame(b, 1'b1));
		sendFrame(b, 1'b1);
		expectStatus(statusWord(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1));   // bad word at head
		readWords(3);

		testName = "overrun";
		for (k = 0; k < overFrames; k++)
		begin
			b = uartPkg::txWord_t'($urandom());
			if (k < uartPkg::fifoDepth)
				rxExpQ.push_back(expectFrame(b, 1'b1));   // last one is lost
			sendFrame(b, 1'b1);
		end
		expectStatus(statusWord(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0));
		readWords(uartPkg::fifoDepth);
		expectStatus(statusWord(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));   // still sticky
		apbWrite(uartRegPkg::regStatus, 32'h1 << uartRegPkg::statOverrun);
		expectStatus(statusWord(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

		testName = "divisor change";
		setDivisor(newDivisor);
		repeat (2 * int'(uartRegPkg::divisorReset))
			@(posedge clk);   // let the baud counter reload
		b = uartPkg::txWord_t'($urandom());
		rxExpQ.push_back(expectFrame(b, 1'b1));
		sendFrame(b, 1'b1);
		readWords(1);
		apbRead(uartRegPkg::regDivisor, rd);
		checkDivisor(16'(newDivisor), rd[uartRegPkg::divisorLen-1:0]);

		$display("All tests passed!");
		$finish;
	end

endmodule

/* uartTop.f */
common/uartPkg.sv
common/uartRegPkg.sv
uart/uartFifo.sv
uart/uartRec.sv
uart/uartTrans.sv
src/baudGen.sv
src/uartRegs.sv
src/uartTop.sv
tests/uartTop_properties.sv
tests/uartTop_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = uartTop_tb
FILELIST  = uartTop.f
LOG       = sim.log
PASS      = All tests passed!

SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
